// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing -Wno-fatal -f mem_sys.f --top-module mem_sys_tb -o Vmem_sys_tb
	./obj_dir/Vmem_sys_tb | tee /dev/stderr | grep -q "^ALL TESTS PASSED$$"

clean:
	rm -rf obj_dir

// File: fetch_port.sv
/* instruction fetch port: address queue with credit return and
   four-byte sequencing that builds little-endian fetch words */
`timescale 1ns/1ns

module fetch_port #(
  parameter int QDEPTH = 2
) (
  input  logic                             clk_in,
  input  logic                             i_rst_n,
  input  logic                             i_fetch_valid,
  input  logic [mem_sys_pkg::ADDR_W-1:0]   i_fetch_addr,
  output logic                             o_fetch_credit,
  output logic                             o_fetch_rsp_valid,
  output logic [mem_sys_pkg::WORD_W-1:0]   o_fetch_rsp_data,
  output logic                             o_bus_req,
  output logic [mem_sys_pkg::ADDR_W-1:0]   o_bus_addr,
  input  logic                             i_bus_grant,
  input  logic                             i_bus_issue,
  input  logic                             i_bus_rd_valid,
  input  logic [mem_sys_pkg::BYTE_W-1:0]   i_bus_rd_byte
);

  localparam int PW = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
  localparam int CW = $clog2(QDEPTH + 1);

  logic [mem_sys_pkg::ADDR_W-1:0] q_addr [QDEPTH];
  logic [PW-1:0]                  wr_ptr, rd_ptr;
  logic [CW-1:0]                  count;
  logic                           active;    // bytes 1..3 still to issue
  logic                           gap;       // one idle cycle marks the end of a transaction
  logic [1:0]                     idx;
  logic [mem_sys_pkg::ADDR_W-1:0] cur_addr;
  logic [1:0]                     sel_idx;
  logic                           step, pop;
  logic [1:0]                     rx_cnt;
  logic [mem_sys_pkg::WORD_W-1:0] word;

  assign sel_idx = active ? idx : 2'd0;
  assign step    = i_bus_grant && i_bus_issue;
  assign pop     = step && !active;          // first byte starts the transaction

  assign o_bus_req      = active || (count != '0 && !gap);
  assign o_bus_addr     = (active ? cur_addr : q_addr[rd_ptr])
                          + {{(mem_sys_pkg::ADDR_W-2){1'b0}}, sel_idx};
  assign o_fetch_credit = pop;

  always_ff @(posedge clk_in) begin
    if (i_fetch_valid)
      q_addr[wr_ptr] <= i_fetch_addr;
    if (pop)
      cur_addr <= q_addr[rd_ptr];
    if (i_bus_rd_valid)
      word <= {i_bus_rd_byte, word[mem_sys_pkg::WORD_W-1:mem_sys_pkg::BYTE_W]};
    o_fetch_rsp_data <= {i_bus_rd_byte, word[mem_sys_pkg::WORD_W-1:mem_sys_pkg::BYTE_W]};
  end

  always_ff @(posedge clk_in or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr            <= '0;
      rd_ptr            <= '0;
      count             <= '0;
      active            <= 1'b0;
      gap               <= 1'b0;
      idx               <= 2'd0;
      rx_cnt            <= 2'd0;
      o_fetch_rsp_valid <= 1'b0;
    end else begin
      if (i_fetch_valid)
        wr_ptr <= (wr_ptr == PW'(QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PW'(QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({i_fetch_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      gap <= step && sel_idx == 2'd3;
      if (step) begin
        active <= sel_idx != 2'd3;
        idx    <= sel_idx + 2'd1;  // wraps to 0 after the last byte
      end
      // read bytes come back in order, four per word
      if (i_bus_rd_valid)
        rx_cnt <= rx_cnt + 2'd1;
      o_fetch_rsp_valid <= i_bus_rd_valid && rx_cnt == 2'd3;
    end
  end

endmodule

// File: lsu_port.sv
/* load/store port: in-order request queue with credit return, byte
   sequencing per access size, and sign or zero extension of loads */
`timescale 1ns/1ns

module lsu_port #(
  parameter int QDEPTH = 2
) (
  input  logic                             clk_in,
  input  logic                             i_rst_n,
  input  logic                             i_ls_valid,
  input  mem_sys_pkg::ls_op_e              i_ls_op,
  input  logic [mem_sys_pkg::ADDR_W-1:0]   i_ls_addr,
  input  logic [mem_sys_pkg::WORD_W-1:0]   i_ls_wdata,
  output logic                             o_ls_credit,
  output logic                             o_ls_rsp_valid,
  output logic [mem_sys_pkg::WORD_W-1:0]   o_ls_rsp_data,
  output logic                             o_bus_req,
  output logic [mem_sys_pkg::ADDR_W-1:0]   o_bus_addr,
  output logic [mem_sys_pkg::BYTE_W-1:0]   o_bus_wdata,
  output logic                             o_bus_wr,
  input  logic                             i_bus_grant,
  input  logic                             i_bus_issue,
  input  logic                             i_bus_rd_valid,
  input  logic [mem_sys_pkg::BYTE_W-1:0]   i_bus_rd_byte
);

  localparam int PW = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
  localparam int CW = $clog2(QDEPTH + 1);
  localparam int BW = mem_sys_pkg::BYTE_W;

  // index of the last byte for each access size
  function automatic logic [1:0] last_idx(input mem_sys_pkg::ls_op_e op);
    case (op)
      mem_sys_pkg::LB, mem_sys_pkg::LBU, mem_sys_pkg::SB: return 2'd0;
      mem_sys_pkg::LH, mem_sys_pkg::LHU, mem_sys_pkg::SH: return 2'd1;
      default:                                            return 2'd3;
    endcase
  endfunction

  function automatic logic is_store(input mem_sys_pkg::ls_op_e op);
    return op == mem_sys_pkg::SB || op == mem_sys_pkg::SH || op == mem_sys_pkg::SW;
  endfunction

  function automatic logic [mem_sys_pkg::WORD_W-1:0] extend(
    input mem_sys_pkg::ls_op_e             op,
    input logic [mem_sys_pkg::WORD_W-1:0]  w
  );
    case (op)
      mem_sys_pkg::LB:  return {{24{w[7]}}, w[7:0]};
      mem_sys_pkg::LH:  return {{16{w[15]}}, w[15:0]};
      mem_sys_pkg::LBU: return {24'd0, w[7:0]};
      mem_sys_pkg::LHU: return {16'd0, w[15:0]};
      default:          return w;
    endcase
  endfunction

  mem_sys_pkg::ls_op_e            q_op    [QDEPTH];
  logic [mem_sys_pkg::ADDR_W-1:0] q_addr  [QDEPTH];
  logic [mem_sys_pkg::WORD_W-1:0] q_wdata [QDEPTH];
  logic [PW-1:0]                  wr_ptr, rd_ptr;
  logic [CW-1:0]                  count;
  logic                           active, gap;
  logic [1:0]                     idx, sel_idx;
  mem_sys_pkg::ls_op_e            cur_op, sel_op;  // cur_op also steers load extension
  logic [mem_sys_pkg::ADDR_W-1:0] cur_addr, sel_addr;
  logic [mem_sys_pkg::WORD_W-1:0] cur_wdata, sel_wdata;
  logic                           step, pop, last_byte;
  logic [1:0]                     rx_cnt;
  logic                           rx_last;
  logic [mem_sys_pkg::WORD_W-1:0] gather, rx_word;

  assign sel_op    = active ? cur_op    : q_op[rd_ptr];
  assign sel_addr  = active ? cur_addr  : q_addr[rd_ptr];
  assign sel_wdata = active ? cur_wdata : q_wdata[rd_ptr];
  assign sel_idx   = active ? idx : 2'd0;
  assign step      = i_bus_grant && i_bus_issue;
  assign pop       = step && !active;
  assign last_byte = sel_idx == last_idx(sel_op);

  assign o_bus_req   = active || (count != '0 && !gap);
  assign o_bus_addr  = sel_addr + {{(mem_sys_pkg::ADDR_W-2){1'b0}}, sel_idx};
  assign o_bus_wdata = sel_wdata[sel_idx*BW +: BW];  // little-endian byte lane
  assign o_bus_wr    = is_store(sel_op);
  assign o_ls_credit = pop;

  // load bytes land in their lane, the current one merged in on the fly
  assign rx_last = rx_cnt == last_idx(cur_op);
  always_comb begin
    rx_word                   = gather;
    rx_word[rx_cnt*BW +: BW]  = i_bus_rd_byte;
  end

  always_ff @(posedge clk_in) begin
    if (i_ls_valid) begin
      q_op[wr_ptr]    <= i_ls_op;
      q_addr[wr_ptr]  <= i_ls_addr;
      q_wdata[wr_ptr] <= i_ls_wdata;
    end
    if (pop) begin
      cur_op    <= q_op[rd_ptr];
      cur_addr  <= q_addr[rd_ptr];
      cur_wdata <= q_wdata[rd_ptr];
    end
    if (i_bus_rd_valid)
      gather <= rx_word;
    o_ls_rsp_data <= extend(cur_op, rx_word);
  end

  always_ff @(posedge clk_in or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      active         <= 1'b0;
      gap            <= 1'b0;
      idx            <= 2'd0;
      rx_cnt         <= 2'd0;
      o_ls_rsp_valid <= 1'b0;
    end else begin
      if (i_ls_valid)
        wr_ptr <= (wr_ptr == PW'(QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PW'(QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({i_ls_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      gap <= step && last_byte;  // request drops for a cycle after the last byte
      if (step) begin
        active <= !last_byte;
        idx    <= last_byte ? 2'd0 : sel_idx + 2'd1;
      end
      if (i_bus_rd_valid)
        rx_cnt <= rx_last ? 2'd0 : rx_cnt + 2'd1;
      o_ls_rsp_valid <= i_bus_rd_valid && rx_last;  // stores never see read bytes
    end
  end

endmodule

// File: mem_arbiter.sv
/* byte bus arbiter: per-transaction grant with alternating priority,
   issue gating on ready and uart full, and read byte return routing */
`timescale 1ns/1ns

module mem_arbiter (
  input  logic                             clk_in,
  input  logic                             i_rst_n,
  input  logic                             i_rdy,
  input  logic                             i_io_buffer_full,
  input  logic                             i_f_req,
  input  logic [mem_sys_pkg::ADDR_W-1:0]   i_f_addr,
  output logic                             o_f_grant,
  output logic                             o_f_issue,
  output logic                             o_f_rd_valid,
  input  logic                             i_l_req,
  input  logic [mem_sys_pkg::ADDR_W-1:0]   i_l_addr,
  input  logic [mem_sys_pkg::BYTE_W-1:0]   i_l_wdata,
  input  logic                             i_l_wr,
  output logic                             o_l_grant,
  output logic                             o_l_issue,
  output logic                             o_l_rd_valid,
  output logic [mem_sys_pkg::BYTE_W-1:0]   o_rd_byte,
  output logic [mem_sys_pkg::ADDR_W-1:0]   o_mem_a,
  output logic [mem_sys_pkg::BYTE_W-1:0]   o_mem_dout,
  output logic                             o_mem_wr,
  input  logic [mem_sys_pkg::BYTE_W-1:0]   i_mem_din
);

  logic own_f, own_l;    // owner of the bus in the previous cycle
  logic last_l;          // load/store port won the last new grant
  logic keep_f, keep_l, bus_free;
  logic new_f, new_l;
  logic io_hold;
  logic rd_f_q, rd_l_q;  // a read was issued last cycle, by whom

  // an owner keeps the bus until it drops its request
  assign keep_f   = own_f && i_f_req;
  assign keep_l   = own_l && i_l_req;
  assign bus_free = !keep_f && !keep_l;

  // both asking on a free bus: the one not served last wins
  assign new_f = bus_free && i_f_req && (!i_l_req || last_l);
  assign new_l = bus_free && i_l_req && (!i_f_req || !last_l);

  assign o_f_grant = keep_f || new_f;
  assign o_l_grant = keep_l || new_l;

  // uart writes wait while its buffer is full
  assign io_hold = i_l_wr && mem_sys_pkg::is_io_addr(i_l_addr) && i_io_buffer_full;

  assign o_f_issue = o_f_grant && i_rdy;
  assign o_l_issue = o_l_grant && i_rdy && !io_hold;

  always_comb begin
    o_mem_a    = '0;  // idle bus parks at address 0
    o_mem_dout = '0;
    o_mem_wr   = 1'b0;
    if (o_f_issue) begin
      o_mem_a = i_f_addr;
    end else if (o_l_issue) begin
      o_mem_a    = i_l_addr;
      o_mem_dout = i_l_wdata;
      o_mem_wr   = i_l_wr;
    end
  end

  // read data shows up one cycle after issue, regardless of i_rdy then
  assign o_rd_byte    = i_mem_din;
  assign o_f_rd_valid = rd_f_q;
  assign o_l_rd_valid = rd_l_q;

  always_ff @(posedge clk_in or negedge i_rst_n) begin
    if (!i_rst_n) begin
      own_f  <= 1'b0;
      own_l  <= 1'b0;
      last_l <= 1'b0;
      rd_f_q <= 1'b0;
      rd_l_q <= 1'b0;
    end else begin
      own_f <= o_f_grant;
      own_l <= o_l_grant;
      if (new_f)
        last_l <= 1'b0;
      else if (new_l)
        last_l <= 1'b1;
      rd_f_q <= o_f_issue;
      rd_l_q <= o_l_issue && !i_l_wr;
    end
  end

endmodule

// File: mem_sys.f
mem_sys_pkg.sv
fetch_port.sv
lsu_port.sv
mem_arbiter.sv
mem_sys.sv
tb_clock_gen.sv
mem_sys_checker.sv
mem_sys_tb.sv

// File: mem_sys.sv
/* memory system top: fetch port and load/store port sharing one
   byte-wide external bus through the arbiter */
`timescale 1ns/1ns

module mem_sys #(
  parameter int QDEPTH = 2  // queue depth and initial credits per port
) (
  input  logic                             clk_in,
  input  logic                             i_rst_n,
  input  logic                             i_rdy,
  input  logic                             i_io_buffer_full,
  input  logic                             i_fetch_valid,
  input  logic [mem_sys_pkg::ADDR_W-1:0]   i_fetch_addr,
  output logic                             o_fetch_credit,
  output logic                             o_fetch_rsp_valid,
  output logic [mem_sys_pkg::WORD_W-1:0]   o_fetch_rsp_data,
  input  logic                             i_ls_valid,
  input  mem_sys_pkg::ls_op_e              i_ls_op,
  input  logic [mem_sys_pkg::ADDR_W-1:0]   i_ls_addr,
  input  logic [mem_sys_pkg::WORD_W-1:0]   i_ls_wdata,
  output logic                             o_ls_credit,
  output logic                             o_ls_rsp_valid,
  output logic [mem_sys_pkg::WORD_W-1:0]   o_ls_rsp_data,
  output logic [mem_sys_pkg::ADDR_W-1:0]   o_mem_a,
  output logic [mem_sys_pkg::BYTE_W-1:0]   o_mem_dout,
  output logic                             o_mem_wr,
  input  logic [mem_sys_pkg::BYTE_W-1:0]   i_mem_din
);

  logic                           f_req, f_grant, f_issue, f_rd_valid;
  logic [mem_sys_pkg::ADDR_W-1:0] f_addr;
  logic                           l_req, l_wr, l_grant, l_issue, l_rd_valid;
  logic [mem_sys_pkg::ADDR_W-1:0] l_addr;
  logic [mem_sys_pkg::BYTE_W-1:0] l_wdata;
  logic [mem_sys_pkg::BYTE_W-1:0] rd_byte;  // shared by both ports

  fetch_port #(.QDEPTH(QDEPTH)) fetch_i (
    .clk_in(clk_in), .i_rst_n(i_rst_n),
    .i_fetch_valid(i_fetch_valid), .i_fetch_addr(i_fetch_addr),
    .o_fetch_credit(o_fetch_credit), .o_fetch_rsp_valid(o_fetch_rsp_valid),
    .o_fetch_rsp_data(o_fetch_rsp_data),
    .o_bus_req(f_req), .o_bus_addr(f_addr), .i_bus_grant(f_grant),
    .i_bus_issue(f_issue), .i_bus_rd_valid(f_rd_valid), .i_bus_rd_byte(rd_byte)
  );

  lsu_port #(.QDEPTH(QDEPTH)) lsu_i (
    .clk_in(clk_in), .i_rst_n(i_rst_n),
    .i_ls_valid(i_ls_valid), .i_ls_op(i_ls_op), .i_ls_addr(i_ls_addr),
    .i_ls_wdata(i_ls_wdata), .o_ls_credit(o_ls_credit),
    .o_ls_rsp_valid(o_ls_rsp_valid), .o_ls_rsp_data(o_ls_rsp_data),
    .o_bus_req(l_req), .o_bus_addr(l_addr), .o_bus_wdata(l_wdata), .o_bus_wr(l_wr),
    .i_bus_grant(l_grant), .i_bus_issue(l_issue), .i_bus_rd_valid(l_rd_valid),
    .i_bus_rd_byte(rd_byte)
  );

  mem_arbiter arb_i (
    .clk_in(clk_in), .i_rst_n(i_rst_n), .i_rdy(i_rdy),
    .i_io_buffer_full(i_io_buffer_full),
    .i_f_req(f_req), .i_f_addr(f_addr), .o_f_grant(f_grant),
    .o_f_issue(f_issue), .o_f_rd_valid(f_rd_valid),
    .i_l_req(l_req), .i_l_addr(l_addr), .i_l_wdata(l_wdata), .i_l_wr(l_wr),
    .o_l_grant(l_grant), .o_l_issue(l_issue), .o_l_rd_valid(l_rd_valid),
    .o_rd_byte(rd_byte),
    .o_mem_a(o_mem_a), .o_mem_dout(o_mem_dout), .o_mem_wr(o_mem_wr),
    .i_mem_din(i_mem_din)
  );

endmodule

// File: mem_sys_checker.sv
/* response checker: reference memory image, expected fetch, load and uart
   queues, credit, bus rule and fairness checks, per-test report lines */
`timescale 1ns/1ns

module mem_sys_checker #(
  parameter int QDEPTH = 2
) (
  input  logic                        clk_in,
  input  logic                        i_rst_n,
  input  logic [7:0]                  i_init_mem [4096],
  input  logic                        i_rdy,
  input  logic                        i_io_buffer_full,
  input  logic                        i_fetch_valid,
  input  logic [31:0]                 i_fetch_addr,
  input  logic                        i_fetch_credit,
  input  logic                        i_fetch_rsp_valid,
  input  logic [31:0]                 i_fetch_rsp_data,
  input  logic                        i_ls_valid,
  input  mem_sys_pkg::ls_op_e         i_ls_op,
  input  logic [31:0]                 i_ls_addr,
  input  logic [31:0]                 i_ls_wdata,
  input  logic                        i_ls_credit,
  input  logic                        i_ls_rsp_valid,
  input  logic [31:0]                 i_ls_rsp_data,
  input  logic [31:0]                 i_mem_a,
  input  logic [7:0]                  i_mem_dout,
  input  logic                        i_mem_wr,
  input  logic                        i_test_end,
  input  int                          i_test_num,
  input  logic                        i_final,
  output int                          o_errors
);

  logic [7:0]  image [4096];
  logic [31:0] exp_fetch [$];
  logic [31:0] exp_load [$];
  logic [7:0]  exp_uart [$];
  int errors = 0;
  int test_base = 0;
  int checks = 0;
  int f_req = 0, l_req = 0, l_loads = 0;
  int f_cred = 0, l_cred = 0, f_rsp = 0, l_rsp = 0;
  int f_out = 0, l_out = 0;     // queued and not yet started
  bit served = 0, last_l = 0, other_waiting = 0;

  assign o_errors = errors;

  function automatic logic [7:0] byte_at(input logic [31:0] a, input int k);
    logic [11:0] idx;
    idx = a[11:0] + 12'(k);
    return image[idx];
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] a);
    return {byte_at(a, 3), byte_at(a, 2), byte_at(a, 1), byte_at(a, 0)};
  endfunction

  // expected load result straight from the RISC-V load rules
  function automatic logic [31:0] load_value(input mem_sys_pkg::ls_op_e op,
                                             input logic [31:0] a);
    logic [31:0] w;
    w = word_at(a);
    case (op)
      mem_sys_pkg::LB:  return {{24{w[7]}}, w[7:0]};
      mem_sys_pkg::LBU: return {24'd0, w[7:0]};
      mem_sys_pkg::LH:  return {{16{w[15]}}, w[15:0]};
      mem_sys_pkg::LHU: return {16'd0, w[15:0]};
      default:          return w;
    endcase
  endfunction

  function automatic string test_name(input int n);
    case (n)
      1: return "fetch only";
      2: return "loads and stores";
      3: return "shared bus, random ready";
      4: return "uart stores, random buffer full";
      default: return "unnamed";
    endcase
  endfunction

  always @(posedge i_rst_n) begin
    for (int i = 0; i < 4096; i++)
      image[i] = i_init_mem[i];
  end

  always @(posedge clk_in) begin : watch
    logic [31:0] w;
    int n;
    if (i_rst_n) begin
      // a port may not start twice in a row while the other waits
      if (i_fetch_credit) begin
        if (served && !last_l && other_waiting) begin
          $display("Error at %0t: fetch port served twice while loads waited", $time);
          errors++;
        end
        served = 1;
        last_l = 0;
        other_waiting = l_out > 0;
      end
      if (i_ls_credit) begin
        if (served && last_l && other_waiting) begin
          $display("Error at %0t: load/store port served twice while fetches waited", $time);
          errors++;
        end
        served = 1;
        last_l = 1;
        other_waiting = f_out > 0;
      end
      f_out += int'(i_fetch_valid) - int'(i_fetch_credit);
      l_out += int'(i_ls_valid) - int'(i_ls_credit);
      if (f_out < 0 || f_out > QDEPTH || l_out < 0 || l_out > QDEPTH) begin
        $display("Error at %0t: %0d fetch and %0d load/store requests queued, allowed 0..%0d",
                 $time, f_out, l_out, QDEPTH);
        errors++;
      end
      f_cred += int'(i_fetch_credit);
      l_cred += int'(i_ls_credit);

      // new requests are predicted in program order
      if (i_fetch_valid) begin
        f_req++;
        exp_fetch.push_back(word_at(i_fetch_addr));
      end
      if (i_ls_valid) begin
        l_req++;
        if (i_ls_op inside {mem_sys_pkg::SB, mem_sys_pkg::SH, mem_sys_pkg::SW}) begin
          n = (i_ls_op == mem_sys_pkg::SB) ? 1 : (i_ls_op == mem_sys_pkg::SH) ? 2 : 4;
          if (i_ls_addr[17:16] == 2'd3) begin
            if (i_ls_addr == 32'h30000)
              exp_uart.push_back(i_ls_wdata[7:0]);
          end else begin
            for (int k = 0; k < n; k++)
              image[i_ls_addr[11:0] + 12'(k)] = i_ls_wdata[8*k +: 8];
          end
        end else begin
          l_loads++;
          exp_load.push_back(load_value(i_ls_op, i_ls_addr));
        end
      end

      if (i_fetch_rsp_valid) begin
        f_rsp++;
        checks++;
        if (exp_fetch.size() == 0) begin
          $display("Error at %0t: fetch response with nothing outstanding", $time);
          errors++;
        end else begin
          w = exp_fetch.pop_front();
          if (i_fetch_rsp_data !== w) begin
            $display("Error at %0t: fetch word %h, expected %h", $time,
                     i_fetch_rsp_data, w);
            errors++;
          end
        end
      end
      if (i_ls_rsp_valid) begin
        l_rsp++;
        checks++;
        if (exp_load.size() == 0) begin
          $display("Error at %0t: load response with nothing outstanding", $time);
          errors++;
        end else begin
          w = exp_load.pop_front();
          if (i_ls_rsp_data !== w) begin
            $display("Error at %0t: load data %h, expected %h", $time, i_ls_rsp_data, w);
            errors++;
          end
        end
      end

      // bus rules on every write byte
      if (i_mem_wr && !i_rdy) begin
        $display("Error at %0t: bus write while i_rdy is low", $time);
        errors++;
      end
      if (i_mem_wr && i_mem_a[17:16] == 2'd3) begin
        if (i_io_buffer_full) begin
          $display("Error at %0t: I/O write while the uart buffer is full", $time);
          errors++;
        end
        if (i_mem_a == 32'h30000) begin
          checks++;
          if (exp_uart.size() == 0) begin
            $display("Error at %0t: uart byte %h was never stored", $time, i_mem_dout);
            errors++;
          end else if (i_mem_dout !== exp_uart[0]) begin
            $display("Error at %0t: uart byte %h, expected %h", $time, i_mem_dout,
                     exp_uart[0]);
            errors++;
            void'(exp_uart.pop_front());
          end else begin
            void'(exp_uart.pop_front());
          end
        end
      end

      if (i_test_end) begin
        $display("test %0d (%s): %s, %0d errors", i_test_num, test_name(i_test_num),
                 (errors == test_base) ? "passed" : "failed", errors - test_base);
        test_base = errors;
      end
      if (i_final) begin
        if (f_cred != f_req || l_cred != l_req) begin
          $display("credit pulses do not match the number of requests");
          errors++;
        end
        if (f_rsp != f_req || l_rsp != l_loads) begin
          $display("response pulses do not match the number of fetches and loads");
          errors++;
        end
        if (exp_fetch.size() != 0 || exp_load.size() != 0 || exp_uart.size() != 0) begin
          $display("some expected responses or uart bytes never arrived");
          errors++;
        end
        $display("%0d checks, %0d errors, %0d fetches, %0d loads/stores", checks, errors,
                 f_req, l_req);
      end
    end
  end

endmodule

// File: mem_sys_pkg.sv
/* shared definitions for the memory side: load/store op codes,
   bus and word widths, and the I/O space address rule */
package mem_sys_pkg;

  // external bus geometry
  localparam int ADDR_W = 32;
  localparam int BYTE_W = 8;   // one byte per bus transfer
  localparam int WORD_W = 32;  // width of fetch and load/store data words

  // I/O space is every address whose bits 17:16 equal IO_SEL
  localparam int IO_MSB = 17;
  localparam int IO_LSB = 16;
  localparam logic [IO_MSB-IO_LSB:0] IO_SEL = 2'd3;

  // load/store operation code carried with each request
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LH  = 3'd1,
    LW  = 3'd2,
    LBU = 3'd3,
    LHU = 3'd4,
    SB  = 3'd5,
    SH  = 3'd6,
    SW  = 3'd7
  } ls_op_e;

  // true when the address falls in the uart / counter window
  function automatic logic is_io_addr(input logic [ADDR_W-1:0] addr);
    return addr[IO_MSB:IO_LSB] == IO_SEL;
  endfunction

endpackage

// File: mem_sys_tb.sv
/* testbench top: LFSR stimulus, byte memory model with uart window,
   credit bookkeeping, test sequence and watchdog */
`timescale 1ns/1ns

module mem_sys_tb;

  localparam int QDEPTH  = 2;
  localparam int N_TOTAL = 260;  // requests over all tests

  logic clk_in, rst_n;
  logic rdy, io_full, fetch_valid, fetch_credit, fetch_rsp_valid;
  logic ls_valid, ls_credit, ls_rsp_valid, mem_wr;
  logic [31:0] fetch_addr, fetch_rsp_data, ls_addr, ls_wdata, ls_rsp_data, mem_a;
  logic [7:0]  mem_dout;
  logic [7:0]  mem_din = '0;
  mem_sys_pkg::ls_op_e ls_op;
  logic [7:0]  mem [4096];
  logic [31:0] lfsr = 32'hb09;
  logic test_end, final_pulse;
  int   test_num, errors;
  int   f_sent = 0, l_sent = 0, l_loads = 0;
  int   f_back = 0, l_back = 0, f_seen = 0, l_seen = 0;

  tb_clock_gen clk_i (.o_clk(clk_in), .o_rst_n(rst_n));

  mem_sys #(.QDEPTH(QDEPTH)) dut_i (
    .clk_in(clk_in), .i_rst_n(rst_n), .i_rdy(rdy), .i_io_buffer_full(io_full),
    .i_fetch_valid(fetch_valid), .i_fetch_addr(fetch_addr), .o_fetch_credit(fetch_credit),
    .o_fetch_rsp_valid(fetch_rsp_valid), .o_fetch_rsp_data(fetch_rsp_data),
    .i_ls_valid(ls_valid), .i_ls_op(ls_op), .i_ls_addr(ls_addr), .i_ls_wdata(ls_wdata),
    .o_ls_credit(ls_credit), .o_ls_rsp_valid(ls_rsp_valid), .o_ls_rsp_data(ls_rsp_data),
    .o_mem_a(mem_a), .o_mem_dout(mem_dout), .o_mem_wr(mem_wr), .i_mem_din(mem_din)
  );

  mem_sys_checker #(.QDEPTH(QDEPTH)) chk_i (
    .clk_in(clk_in), .i_rst_n(rst_n), .i_init_mem(mem), .i_rdy(rdy),
    .i_io_buffer_full(io_full), .i_fetch_valid(fetch_valid), .i_fetch_addr(fetch_addr),
    .i_fetch_credit(fetch_credit), .i_fetch_rsp_valid(fetch_rsp_valid),
    .i_fetch_rsp_data(fetch_rsp_data), .i_ls_valid(ls_valid), .i_ls_op(ls_op),
    .i_ls_addr(ls_addr), .i_ls_wdata(ls_wdata), .i_ls_credit(ls_credit),
    .i_ls_rsp_valid(ls_rsp_valid), .i_ls_rsp_data(ls_rsp_data), .i_mem_a(mem_a),
    .i_mem_dout(mem_dout), .i_mem_wr(mem_wr), .i_test_end(test_end),
    .i_test_num(test_num), .i_final(final_pulse), .o_errors(errors)
  );

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // byte memory with read data valid the cycle after the address and I/O writes not stored
  always @(posedge clk_in) begin
    mem_din <= mem[mem_a[11:0]];
    if (mem_wr && mem_a[17:16] != 2'd3)
      mem[mem_a[11:0]] = mem_dout;
  end

  always @(posedge clk_in) begin
    f_back += int'(fetch_credit);
    l_back += int'(ls_credit);
    f_seen += int'(fetch_rsp_valid);
    l_seen += int'(ls_rsp_valid);
  end

  task automatic run_traffic(input int nf, input int nl, input bit rdy_rand, input bit uart);
    int f_left, l_left;
    logic [31:0] r, a, d;
    mem_sys_pkg::ls_op_e op;
    f_left = nf;
    l_left = nl;
    while (f_left > 0 || l_left > 0) begin
      @(negedge clk_in);
      fetch_valid = 1'b0;
      ls_valid    = 1'b0;
      rand_bits(1, r);
      if (f_left > 0 && f_sent - f_back < QDEPTH && r[0]) begin
        rand_bits(9, a);
        fetch_addr  = {21'd0, a[8:0], 2'b00};  // aligned within bytes 0..2047
        fetch_valid = 1'b1;
        f_sent++;
        f_left--;
      end
      rand_bits(1, r);
      if (l_left > 0 && l_sent - l_back < QDEPTH && r[0]) begin
        rand_bits(3, r);
        op = mem_sys_pkg::ls_op_e'(r[2:0]);
        rand_bits(11, a);
        if (op inside {mem_sys_pkg::LH, mem_sys_pkg::LHU, mem_sys_pkg::SH})
          a[0] = 1'b0;
        else if (op inside {mem_sys_pkg::LW, mem_sys_pkg::SW})
          a[1:0] = 2'b00;
        a = 32'd2048 + {21'd0, a[10:0]};
        rand_bits(2, r);
        if (uart && r[1:0] == 2'd0) begin
          op = mem_sys_pkg::SB;
          a  = 32'h30000;  // uart data register
        end
        rand_bits(32, d);
        ls_op    = op;
        ls_addr  = a;
        ls_wdata = d;
        ls_valid = 1'b1;
        if (!(op inside {mem_sys_pkg::SB, mem_sys_pkg::SH, mem_sys_pkg::SW}))
          l_loads++;
        l_sent++;
        l_left--;
      end
      if (rdy_rand) begin
        rand_bits(2, r);
        rdy = r[1:0] != 2'd0;
      end
      if (uart) begin
        rand_bits(1, r);
        io_full = r[0];
      end
    end
    @(negedge clk_in);
    fetch_valid = 1'b0;
    ls_valid    = 1'b0;
    rdy         = 1'b1;
    io_full     = 1'b0;
  endtask

  task automatic finish_test(input int n);
    while (f_seen < f_sent || l_seen < l_loads || f_back < f_sent || l_back < l_sent)
      @(negedge clk_in);
    repeat (6) @(negedge clk_in);  // let trailing store bytes reach the bus
    test_num = n;
    test_end = 1'b1;
    @(negedge clk_in);
    test_end = 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    rdy = 1'b1;
    io_full = 1'b0;
    fetch_valid = 1'b0;
    fetch_addr = '0;
    ls_valid = 1'b0;
    ls_op = mem_sys_pkg::LB;
    ls_addr = '0;
    ls_wdata = '0;
    test_end = 1'b0;
    test_num = 0;
    final_pulse = 1'b0;
    for (int i = 0; i < 4096; i++) begin
      rand_bits(8, r);
      mem[i] = r[7:0];
    end
    @(posedge rst_n);
    run_traffic(40, 0, 1'b0, 1'b0);
    finish_test(1);
    run_traffic(0, 60, 1'b0, 1'b0);
    finish_test(2);
    run_traffic(40, 60, 1'b1, 1'b0);
    finish_test(3);
    run_traffic(20, 40, 1'b1, 1'b1);
    finish_test(4);
    final_pulse = 1'b1;
    @(negedge clk_in);
    final_pulse = 1'b0;
    @(negedge clk_in);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // watchdog allows 40 cycles per request plus a margin
  initial begin
    #(N_TOTAL * 40 * 8 + 4000);
    $display("timeout: the run did not finish in the expected time");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: tb_clock_gen.sv
/* testbench clock and reset source */
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int HALF_PERIOD = 4,  // 8 ns clock
  parameter int RST_CYCLES  = 5
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk   = 1'b0;
    o_rst_n = 1'b0;
    fork
      forever #(HALF_PERIOD) o_clk = ~o_clk;
      begin
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk) o_rst_n = 1'b1;  // release away from the active edge
      end
    join
  end

endmodule
